// ==== upMemPkg.sv ====
package upMemPkg;

	localparam int dataWidth = 8;
	localparam int addrWidth = 8;
	localparam int memDepth = 1 << addrWidth;

	localparam logic [addrWidth-1:0] outAddr = 8'd127; // Store here strobes the output

	// Boot program with its data block at 128
	localparam logic [dataWidth-1:0] bootImage [0:memDepth-1] = '{
		0: 8'h10, // LDI 0x05
		1: 8'h05,
		2: 8'h40, // ADD 128
		3: 8'h80,
		4: 8'h30, // STA 127
		5: 8'h7F,
		6: 8'h80, // XOR 129
		7: 8'h81,
		8: 8'h30, // STA 127
		9: 8'h7F,
		10: 8'hF0, // HLT
		128: 8'hBC,
		129: 8'h45,
		130: 8'h6B,
		131: 8'hC0,
		132: 8'h45,
		133: 8'hDA,
		134: 8'h65,
		135: 8'h4D,
		136: 8'hA8,
		default: 8'h00
	};

endpackage

// ==== upIsaPkg.sv ====
package upIsaPkg;

	localparam int opcodeWidth = 4;

	// Opcode sits in the high nibble of the first byte
	typedef enum logic [opcodeWidth-1:0] {
		opNop = 4'h0,
		opLdi = 4'h1,
		opLda = 4'h2,
		opSta = 4'h3,
		opAdd = 4'h4,
		opSub = 4'h5,
		opAnd = 4'h6,
		opOr  = 4'h7,
		opXor = 4'h8,
		opJmp = 4'h9,
		opJz  = 4'hA,
		opJc  = 4'hB,
		opShl = 4'hC,
		opShr = 4'hD,
		opHlt = 4'hF // 4'hE runs as NOP
	} opcode;

	typedef enum logic [2:0] {
		aluPass = 3'd0, // Result is operand b
		aluAdd  = 3'd1,
		aluSub  = 3'd2,
		aluAnd  = 3'd3,
		aluOr   = 3'd4,
		aluXor  = 3'd5,
		aluShl  = 3'd6,
		aluShr  = 3'd7
	} aluOp;

	// Low nibble of the instruction byte is ignored
	function automatic opcode opcodeOf(logic [7:0] instrByte);
		return opcode'(instrByte[7 -: opcodeWidth]);
	endfunction

	// LDI through JC carry one operand byte
	function automatic logic hasOperand(opcode op);
		return (op >= opLdi) && (op <= opJc);
	endfunction

	function automatic logic writesAcc(opcode op);
		return op inside {opLdi, opLda, opAdd, opSub, opAnd, opOr, opXor, opShl, opShr};
	endfunction

endpackage

// ==== upMemory.sv ====
`timescale 1ns/1ps

module upMemory
	import upMemPkg::*;
(
	input  logic                 clk,
	input  logic                 nRst,
	input  logic [addrWidth-1:0] addr,
	input  logic [dataWidth-1:0] wData,
	input  logic                 write,
	output logic [dataWidth-1:0] rData
);

	logic [dataWidth-1:0] mem [0:memDepth-1];

	assign rData = mem[addr]; // Asynchronous read

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			mem <= bootImage; // Boot image reloads on every reset
		end else if (write) begin
			mem[addr] <= wData;
		end
	end

endmodule

// ==== upAlu.sv ====
`timescale 1ns/1ps

module upAlu
	import upMemPkg::*, upIsaPkg::*;
(
	input  aluOp                 op,
	input  logic [dataWidth-1:0] a,
	input  logic [dataWidth-1:0] b,
	input  logic                 carryIn,
	output logic [dataWidth-1:0] result,
	output logic                 zero,
	output logic                 carry
);

	logic [dataWidth:0] wide; // One extra bit for carry or borrow

	always_comb begin
		wide = '0;
		result = b;
		carry = carryIn; // Kept unless the op defines carry
		case (op)
			aluPass: begin
				result = b;
			end
			aluAdd: begin
				wide = {1'b0, a} + {1'b0, b};
				result = wide[dataWidth-1:0];
				carry = wide[dataWidth];
			end
			aluSub: begin
				wide = {1'b0, a} - {1'b0, b};
				result = wide[dataWidth-1:0];
				carry = wide[dataWidth]; // Borrow
			end
			aluAnd: begin
				result = a & b;
			end
			aluOr: begin
				result = a | b;
			end
			aluXor: begin
				result = a ^ b;
			end
			aluShl: begin
				result = {a[dataWidth-2:0], 1'b0};
				carry = a[dataWidth-1];
			end
			aluShr: begin
				result = {1'b0, a[dataWidth-1:1]};
				carry = a[0];
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

// ==== upSequencer.sv ====
`timescale 1ns/1ps

module upSequencer
	import upMemPkg::*, upIsaPkg::*;
(
	input  logic                 clk,
	input  logic                 nRst,

	input  logic                 loadStrobe,
	input  logic [addrWidth-1:0] loadAddr,
	input  logic [dataWidth-1:0] loadData,
	input  logic                 startStrobe,

	output logic                 halted,
	output logic                 outStrobe,
	output logic [dataWidth-1:0] outData,

	output logic [addrWidth-1:0] memAddr,
	output logic                 memWrite,
	output logic [dataWidth-1:0] memWData,
	input  logic [dataWidth-1:0] memRData,

	output upIsaPkg::aluOp       aluOp,
	output logic [dataWidth-1:0] aluA,
	output logic [dataWidth-1:0] aluB,
	output logic                 carryIn,
	input  logic [dataWidth-1:0] aluResult,
	input  logic                 aluZero,
	input  logic                 aluCarry
);

	typedef enum logic [1:0] {
		sFetch,
		sOperand,
		sExecute,
		sHalt
	} seqState;

	seqState              state;
	opcode                instr;
	logic [dataWidth-1:0] operand;
	logic [addrWidth-1:0] pc;
	logic [dataWidth-1:0] acc;
	logic                 zeroFlag;
	logic                 carryFlag;
	logic                 takeJump;

	// Memory port owner depends on state
	always_comb begin
		memAddr = pc;
		memWrite = 1'b0;
		memWData = acc;
		case (state)
			sFetch, sOperand: begin
				memAddr = pc;
			end
			sExecute: begin
				memAddr = operand;
				memWrite = (instr == opSta);
			end
			sHalt: begin
				memAddr = loadAddr; // Loader only while halted
				memWrite = loadStrobe;
				memWData = loadData;
			end
		endcase
	end

	always_comb begin
		case (instr)
			opAdd: aluOp = aluAdd;
			opSub: aluOp = aluSub;
			opAnd: aluOp = aluAnd;
			opOr:  aluOp = aluOr;
			opXor: aluOp = aluXor;
			opShl: aluOp = aluShl;
			opShr: aluOp = aluShr;
			default: aluOp = aluPass;
		endcase
	end

	assign aluA = acc;
	assign aluB = (instr == opLdi) ? operand : memRData; // Memory byte read in execute
	assign carryIn = carryFlag;

	always_comb begin
		case (instr)
			opJmp: takeJump = 1'b1;
			opJz:  takeJump = zeroFlag;
			opJc:  takeJump = carryFlag;
			default: takeJump = 1'b0;
		endcase
	end

	assign halted = (state == sHalt);
	assign outStrobe = (state == sExecute) && (instr == opSta) && (operand == outAddr);
	assign outData = acc;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= sFetch;
			instr <= opNop;
			operand <= '0;
			pc <= '0;
			acc <= '0;
			zeroFlag <= 1'b0;
			carryFlag <= 1'b0;
		end else begin
			case (state)
				sFetch: begin
					instr <= opcodeOf(memRData);
					pc <= pc + 1'b1; // Wraps modulo 256
					state <= hasOperand(opcodeOf(memRData)) ? sOperand : sExecute;
				end
				sOperand: begin
					operand <= memRData;
					pc <= pc + 1'b1;
					state <= sExecute;
				end
				sExecute: begin
					if (writesAcc(instr)) begin
						acc <= aluResult;
						zeroFlag <= aluZero;
						carryFlag <= aluCarry; // Passed through for LDI, LDA, logic
					end
					if (takeJump) begin
						pc <= operand;
					end
					state <= (instr == opHlt) ? sHalt : sFetch;
				end
				sHalt: begin
					if (startStrobe) begin
						pc <= '0;
						acc <= '0;
						zeroFlag <= 1'b0;
						carryFlag <= 1'b0;
						state <= sFetch;
					end
				end
			endcase
		end
	end

endmodule

// ==== upCore.sv ====
`timescale 1ns/1ps

module upCore
	import upMemPkg::*, upIsaPkg::*;
(
	input  logic                 clk,
	input  logic                 nRst,
	input  logic                 loadStrobe,
	input  logic [addrWidth-1:0] loadAddr,
	input  logic [dataWidth-1:0] loadData,
	input  logic                 startStrobe,
	output logic                 halted,
	output logic                 outStrobe,
	output logic [dataWidth-1:0] outData
);

	logic [addrWidth-1:0] memAddr;
	logic                 memWrite;
	logic [dataWidth-1:0] memWData;
	logic [dataWidth-1:0] memRData;

	aluOp                 aluSel;
	logic [dataWidth-1:0] aluA;
	logic [dataWidth-1:0] aluB;
	logic                 carryIn;
	logic [dataWidth-1:0] aluResult;
	logic                 aluZero;
	logic                 aluCarry;

	upSequencer upSequencer_inst (
		.clk         (clk),
		.nRst        (nRst),
		.loadStrobe  (loadStrobe),
		.loadAddr    (loadAddr),
		.loadData    (loadData),
		.startStrobe (startStrobe),
		.halted      (halted),
		.outStrobe   (outStrobe),
		.outData     (outData),
		.memAddr     (memAddr),
		.memWrite    (memWrite),
		.memWData    (memWData),
		.memRData    (memRData),
		.aluOp       (aluSel),
		.aluA        (aluA),
		.aluB        (aluB),
		.carryIn     (carryIn),
		.aluResult   (aluResult),
		.aluZero     (aluZero),
		.aluCarry    (aluCarry)
	);

	upAlu upAlu_inst (
		.op      (aluSel),
		.a       (aluA),
		.b       (aluB),
		.carryIn (carryIn),
		.result  (aluResult),
		.zero    (aluZero),
		.carry   (aluCarry)
	);

	upMemory upMemory_inst (
		.clk   (clk),
		.nRst  (nRst),
		.addr  (memAddr),
		.wData (memWData),
		.write (memWrite),
		.rData (memRData)
	);

endmodule

// ==== upCore_checker.sv ====
`timescale 1ns/1ps

module upCore_checker (
	input logic clk,
	input logic nRst,
	input logic startStrobe,
	input logic halted,
	input logic outStrobe
);

	int assertFails = 0;

	property noStrobeWhileHalted;
		@(posedge clk) disable iff (!nRst) !(halted && outStrobe);
	endproperty

	// Start only takes effect from halt
	property haltedFallsAfterStart;
		@(posedge clk) disable iff (!nRst) (halted && startStrobe) |=> !halted;
	endproperty

	property statusKnown;
		@(posedge clk) disable iff (!nRst) !$isunknown({halted, outStrobe});
	endproperty

	assert property (noStrobeWhileHalted)
		else begin
			$error("outStrobe asserted while the core is halted");
			assertFails++;
		end

	assert property (haltedFallsAfterStart)
		else begin
			$error("halted stayed high after an accepted startStrobe");
			assertFails++;
		end

	assert property (statusKnown)
		else begin
			$error("halted or outStrobe is unknown after reset");
			assertFails++;
		end

endmodule

bind upCore upCore_checker upCore_checker_inst (
	.clk         (clk),
	.nRst        (nRst),
	.startStrobe (startStrobe),
	.halted      (halted),
	.outStrobe   (outStrobe)
);

// ==== upCore_tb.sv ====
`timescale 1ns/1ps

module upCore_tb
	import upMemPkg::*, upIsaPkg::*;
();

	localparam int timeoutCycles = 5000;

	logic                 clk;
	logic                 nRst;
	logic                 loadStrobe;
	logic [addrWidth-1:0] loadAddr;
	logic [dataWidth-1:0] loadData;
	logic                 startStrobe;
	logic                 halted;
	logic                 outStrobe;
	logic [dataWidth-1:0] outData;

	logic [dataWidth-1:0] shadow [0:memDepth-1]; // Mirror of DUT memory
	logic [dataWidth-1:0] prog [$];
	logic [dataWidth-1:0] expOut [$];
	logic [dataWidth-1:0] dutOut [$];
	int                   errorCount;
	int                   passCount;
	int                   failCount;
	bit                   timedOut;

	upCore upCore_inst (
		.clk         (clk),
		.nRst        (nRst),
		.loadStrobe  (loadStrobe),
		.loadAddr    (loadAddr),
		.loadData    (loadData),
		.startStrobe (startStrobe),
		.halted      (halted),
		.outStrobe   (outStrobe),
		.outData     (outData)
	);

	always #50 clk = ~clk;

	always @(negedge clk) begin
		if (nRst === 1'b1 && outStrobe === 1'b1) begin
			dutOut.push_back(outData);
		end
	end

	function automatic logic takesOperand(logic [3:0] nib);
		return (nib >= 4'h1) && (nib <= 4'hB); // LDI up to JC
	endfunction

	// Instruction-set interpreter, code and data share shadow
	task automatic modelRun();
		logic [dataWidth-1:0] pc;
		logic [dataWidth-1:0] acc;
		logic [dataWidth-1:0] arg;
		logic [dataWidth-1:0] val;
		logic [dataWidth:0]   sum;
		logic [3:0]           nib;
		logic                 zf;
		logic                 cf;
		logic                 done;
		opcode                op;
		int                   steps;
		pc = '0;
		acc = '0;
		zf = 1'b0;
		cf = 1'b0;
		done = 1'b0;
		steps = 0;
		expOut.delete();
		while (!done && steps < timeoutCycles) begin
			nib = shadow[pc][7:4];
			op = opcode'(nib);
			pc = pc + 8'd1;
			arg = '0;
			if (takesOperand(nib)) begin
				arg = shadow[pc];
				pc = pc + 8'd1;
			end
			val = shadow[arg];
			case (op)
				opLdi: acc = arg;
				opLda: acc = val;
				opSta: begin
					shadow[arg] = acc;
					if (arg == outAddr) begin
						expOut.push_back(acc);
					end
				end
				opAdd: begin
					sum = {1'b0, acc} + {1'b0, val};
					acc = sum[dataWidth-1:0];
					cf = sum[dataWidth];
				end
				opSub: begin
					cf = (acc < val); // Borrow
					acc = acc - val;
				end
				opAnd: acc = acc & val;
				opOr:  acc = acc | val;
				opXor: acc = acc ^ val;
				opJmp: pc = arg;
				opJz:  pc = zf ? arg : pc;
				opJc:  pc = cf ? arg : pc;
				opShl: begin
					cf = acc[dataWidth-1];
					acc = acc << 1;
				end
				opShr: begin
					cf = acc[0];
					acc = acc >> 1;
				end
				opHlt: done = 1'b1;
				default: ; // NOP and 4'hE
			endcase
			if (op inside {opLdi, opLda, opAdd, opSub, opAnd, opOr, opXor, opShl, opShr}) begin
				zf = (acc == '0);
			end
			steps++;
		end
	endtask

	task automatic compareByte(string name, logic [dataWidth-1:0] expected,
			logic [dataWidth-1:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic compareCount(string name, int expected, int actual);
		if (actual != expected) begin
			$display("** Error %s output count: expected %0d, actual %0d", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic loadByte(int addr, logic [dataWidth-1:0] data, bit accepted);
		@(posedge clk);
		loadStrobe <= 1'b1;
		loadAddr <= addr[addrWidth-1:0];
		loadData <= data;
		if (accepted) begin
			shadow[addr] = data;
		end
	endtask

	task automatic loadProgram();
		for (int i = 0; i < prog.size(); i++) begin
			loadByte(i, prog[i], 1'b1);
		end
	endtask

	task automatic startRun();
		@(posedge clk);
		loadStrobe <= 1'b0;
		startStrobe <= 1'b1;
		@(posedge clk);
		startStrobe <= 1'b0;
	endtask

	task automatic waitHalted(string name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (halted !== 1'b1 && cycles < timeoutCycles) begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1) begin
			$display("Timeout: %s did not halt within %0d cycles", name, timeoutCycles);
			failCount++;
			timedOut = 1'b1;
		end
	endtask

	task automatic checkOutputs(string name, int errBefore);
		int n;
		compareCount(name, expOut.size(), dutOut.size());
		n = (expOut.size() < dutOut.size()) ? expOut.size() : dutOut.size();
		for (int i = 0; i < n; i++) begin
			compareByte($sformatf("%s byte %0d", name, i), expOut[i], dutOut[i]);
		end
		if (errorCount == errBefore) begin
			passCount++;
			$display("test %s: passed, %0d outputs", name, dutOut.size());
		end else begin
			failCount++;
			$display("test %s: failed", name);
		end
	endtask

	task automatic runProgram(string name);
		int errBefore;
		errBefore = errorCount;
		modelRun();
		dutOut.delete();
		startRun();
		waitHalted(name);
		if (!timedOut) begin
			checkOutputs(name, errBefore);
		end
	endtask

	// Forward-only jumps and stores outside the code keep every program finite
	task automatic genRandomProgram();
		logic [3:0]           ops [0:29];
		int                   addrOf [0:30];
		int                   a;
		logic [dataWidth-1:0] arg;
		a = 0;
		for (int i = 0; i < 30; i++) begin
			ops[i] = 4'($urandom_range(14, 0));
			addrOf[i] = a;
			a += takesOperand(ops[i]) ? 2 : 1;
		end
		addrOf[30] = a; // Final HLT
		prog.delete();
		for (int i = 0; i <= 126; i++) begin
			prog.push_back({4'hF, 4'($urandom)});
		end
		for (int i = 0; i < 30; i++) begin
			prog[addrOf[i]] = {ops[i], 4'($urandom)};
			if (takesOperand(ops[i])) begin
				case (ops[i])
					opJmp, opJz, opJc: arg = 8'(addrOf[$urandom_range(30, i + 1)]);
					opSta: arg = ($urandom_range(1, 0) == 0) ? outAddr : 8'($urandom_range(255, 128));
					default: arg = 8'($urandom);
				endcase
				prog[addrOf[i] + 1] = arg;
			end
		end
	endtask

	task automatic ignoredLoadRun();
		int errBefore;
		errBefore = errorCount;
		for (int k = 0; k < 4; k++) begin
			loadByte(200 + k, 8'($urandom), 1'b1);
		end
		prog.delete();
		for (int i = 0; i < 40; i++) begin
			prog.push_back(8'h00); // Delay so the core is busy during loads
		end
		for (int k = 0; k < 4; k++) begin
			prog.push_back(8'h20);
			prog.push_back(8'(200 + k));
			prog.push_back(8'h30);
			prog.push_back(outAddr);
		end
		prog.push_back(8'hF0);
		loadProgram();
		modelRun();
		dutOut.delete();
		startRun();
		for (int k = 0; k < 4; k++) begin
			loadByte(200 + k, ~shadow[200 + k], 1'b0);
		end
		@(posedge clk);
		loadStrobe <= 1'b0;
		@(negedge clk);
		if (halted) begin
			$display("Core halted before the ignored loads were sent in ignored loads");
			errorCount++;
		end
		waitHalted("ignored loads");
		if (!timedOut) begin
			checkOutputs("ignored loads", errBefore);
		end
	endtask

	initial begin
		clk = 1'b0;
		nRst = 1'b0;
		loadStrobe = 1'b0;
		loadAddr = '0;
		loadData = '0;
		startStrobe = 1'b0;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		timedOut = 1'b0;
		void'($urandom(65));
		for (int i = 0; i < memDepth; i++) begin
			shadow[i] = bootImage[i];
		end
		repeat (10) @(posedge clk);
		nRst <= 1'b1;

		dutOut.delete();
		modelRun();
		waitHalted("boot run");
		if (!timedOut) begin
			checkOutputs("boot run", 0);
		end

		for (int n = 0; n < 20 && !timedOut; n++) begin
			genRandomProgram();
			loadProgram();
			for (int a = 128; a < memDepth; a++) begin
				loadByte(a, 8'($urandom), 1'b1);
			end
			runProgram($sformatf("random program %0d", n));
		end

		// ADD carry into JC, SUB zero into JZ, then SHL and SHR carry-out
		if (!timedOut) begin
			prog = '{8'h10, 8'hF0, 8'h40, 8'h80, 8'hB0, 8'h0A, 8'h10, 8'h11, 8'h30, 8'h7F,
				8'h30, 8'h7F, 8'h10, 8'h20, 8'h50, 8'h80, 8'hA0, 8'h16, 8'h10, 8'h33,
				8'h30, 8'h7F, 8'hB0, 8'h1A, 8'h10, 8'h44, 8'h30, 8'h7F, 8'h10, 8'h81,
				8'hC0, 8'h30, 8'h7F, 8'hB0, 8'h27, 8'h10, 8'h55, 8'h30, 8'h7F, 8'hD0,
				8'h30, 8'h7F, 8'hD0, 8'hB0, 8'h2F, 8'h30, 8'h7F, 8'hA0, 8'h33, 8'h10,
				8'h66, 8'h30, 8'h7F, 8'hF0};
			loadProgram();
			loadByte(128, 8'h20, 1'b1);
			runProgram("flags and branches");
		end

		// Turns the HLT at 10 into STA 127 before reaching it
		if (!timedOut) begin
			prog = '{8'h10, 8'h7F, 8'h30, 8'h0B, 8'h10, 8'h30, 8'h30, 8'h0A, 8'h10, 8'h5A,
				8'hF0, 8'h00, 8'h80, 8'h80, 8'h30, 8'h7F, 8'hF0};
			loadProgram();
			loadByte(128, 8'h0F, 1'b1);
			runProgram("self-modifying stores");
		end

		if (!timedOut) begin
			ignoredLoadRun();
		end

		$display("Tests passed: %0d, failed: %0d, assertion failures: %0d", passCount, failCount,
			upCore_inst.upCore_checker_inst.assertFails);
		if (failCount == 0 && upCore_inst.upCore_checker_inst.assertFails == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
upMemPkg.sv
upIsaPkg.sv
upMemory.sv
upAlu.sv
upSequencer.sv
upCore.sv
upCore_checker.sv
upCore_tb.sv
